//--- src/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // Fetch block geometry
    localparam int FETCH_WIDTH = 4;
    localparam int INSTR_WIDTH = 32;
    localparam int INSTR_BYTES = INSTR_WIDTH / 8;
    localparam int ADDR_WIDTH = 32;
    localparam int BLOCK_BYTES = FETCH_WIDTH * INSTR_BYTES;

    // Instruction cache, two read ports
    localparam int CACHE_PORTS = 2;
    localparam int LINE_WIDTH = 128;
    localparam int LINE_BYTES = LINE_WIDTH / 8;

    // Boot address
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c00_0000;

    // Fetch target queue
    localparam int FTQ_DEPTH = 4;
    localparam int FTQ_PTR_WIDTH = 2;

    // IDLE waits for a block, WAIT collects lines, HOLD presents lanes
    typedef enum logic [1:0] {
        IFU_IDLE = 2'd0,
        IFU_WAIT = 2'd1,
        IFU_HOLD = 2'd2
    } ifu_state_e;

endpackage

//--- src/instr_info_pkg.sv
package instr_info_pkg;

    // Predecode classes handed to the instruction buffer
    typedef enum logic [1:0] {
        CLS_ALU    = 2'd0,
        CLS_MEM    = 2'd1,
        CLS_JUMP   = 2'd2,
        CLS_BRANCH = 2'd3
    } instr_class_e;

    // Major opcode field
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int OPC_WIDTH = OPC_MSB - OPC_LSB + 1;

    // Unconditional jumps, b and bl
    localparam logic [OPC_WIDTH-1:0] OPC_JUMP_B = 6'b010100;
    localparam logic [OPC_WIDTH-1:0] OPC_JUMP_BL = 6'b010101;

    // Conditional branches occupy a contiguous range
    localparam logic [OPC_WIDTH-1:0] OPC_BRANCH_LO = 6'b010110;
    localparam logic [OPC_WIDTH-1:0] OPC_BRANCH_HI = 6'b011011;

    // Loads and stores share this prefix
    localparam logic [OPC_WIDTH-1:0] OPC_MEM = 6'b001010;

endpackage

//--- src/ftq.sv
`timescale 1ns/1ps

module ftq
    import fetch_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,

    // Block generator side
    input  logic                  blk_valid_i,
    input  logic [ADDR_WIDTH-1:0] blk_pc_i,
    input  logic                  blk_cross_i,
    output logic                  full_o,

    // Backend commit pulse
    input  logic                  commit_i,

    // IFU side
    output logic                  ifu_valid_o,
    output logic [ADDR_WIDTH-1:0] ifu_pc_o,
    output logic                  ifu_cross_o,
    input  logic                  ifu_accept_i
);

    logic [ADDR_WIDTH-1:0]    pc_mem [FTQ_DEPTH];
    logic [FTQ_DEPTH-1:0]     cross_mem;

    logic [FTQ_PTR_WIDTH-1:0] enq_ptr_q;
    logic [FTQ_PTR_WIDTH-1:0] iss_ptr_q;
    logic [FTQ_PTR_WIDTH-1:0] cmt_ptr_q;
    logic [FTQ_DEPTH-1:0]     issued_q;

    // Enqueued and not committed, enqueued and not issued
    logic [FTQ_PTR_WIDTH:0]   occ_q;
    logic [FTQ_PTR_WIDTH:0]   unissued_q;

    logic                     do_enq;
    logic                     do_issue;
    logic                     do_commit;

    assign full_o = (occ_q == (FTQ_PTR_WIDTH + 1)'(FTQ_DEPTH));
    assign do_enq = blk_valid_i && !full_o;

    assign ifu_valid_o = (unissued_q != '0);
    assign ifu_pc_o = pc_mem[iss_ptr_q];
    assign ifu_cross_o = cross_mem[iss_ptr_q];
    assign do_issue = ifu_accept_i && ifu_valid_o;

    // Only an entry already handed to the IFU can retire
    assign do_commit = commit_i && issued_q[cmt_ptr_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_ptr_q <= '0;
            iss_ptr_q <= '0;
            cmt_ptr_q <= '0;
            issued_q <= '0;
            occ_q <= '0;
            unissued_q <= '0;
        end else if (flush_i) begin
            enq_ptr_q <= '0;
            iss_ptr_q <= '0;
            cmt_ptr_q <= '0;
            issued_q <= '0;
            occ_q <= '0;
            unissued_q <= '0;
        end else begin
            if (do_enq) begin
                enq_ptr_q <= enq_ptr_q + 1'b1;
            end
            if (do_issue) begin
                iss_ptr_q <= iss_ptr_q + 1'b1;
                issued_q[iss_ptr_q] <= 1'b1;
            end
            if (do_commit) begin
                cmt_ptr_q <= cmt_ptr_q + 1'b1;
                issued_q[cmt_ptr_q] <= 1'b0;
            end
            occ_q <= occ_q + (FTQ_PTR_WIDTH + 1)'(do_enq)
                     - (FTQ_PTR_WIDTH + 1)'(do_commit);
            unissued_q <= unissued_q + (FTQ_PTR_WIDTH + 1)'(do_enq)
                          - (FTQ_PTR_WIDTH + 1)'(do_issue);
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (do_enq) begin
            pc_mem[enq_ptr_q] <= blk_pc_i;
            cross_mem[enq_ptr_q] <= blk_cross_i;
        end
    end

endmodule

//--- src/ifu.sv
`timescale 1ns/1ps

module ifu
    import fetch_cfg_pkg::*;
    import instr_info_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     flush_i,

    // FTQ side
    input  logic                                     ftq_valid_i,
    input  logic [ADDR_WIDTH-1:0]                    ftq_pc_i,
    input  logic                                     ftq_cross_i,
    output logic                                     ftq_accept_o,

    // Instruction cache, two read ports
    output logic [CACHE_PORTS-1:0]                   icache_req_o,
    output logic [CACHE_PORTS-1:0][ADDR_WIDTH-1:0]   icache_addr_o,
    input  logic [CACHE_PORTS-1:0]                   icache_valid_i,
    input  logic [CACHE_PORTS-1:0][LINE_WIDTH-1:0]   icache_data_i,

    // Instruction buffer
    input  logic                                     stall_i,
    output logic [FETCH_WIDTH-1:0]                   instr_valid_o,
    output logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]   instr_pc_o,
    output logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0]  instr_o,
    output instr_class_e [FETCH_WIDTH-1:0]           instr_class_o
);

    ifu_state_e                                state_q;
    logic [ADDR_WIDTH-1:0]                     blk_pc_q;
    logic [ADDR_WIDTH-1:0]                     line_base;
    logic [CACHE_PORTS-1:0][LINE_WIDTH-1:0]    line_q;
    logic [CACHE_PORTS-1:0][LINE_WIDTH-1:0]    line_m;
    logic [CACHE_PORTS-1:0]                    req_left;
    logic                                      drop_q;
    logic                                      ports_free;
    logic                                      accept;
    logic                                      lines_done;
    logic [CACHE_PORTS*LINE_WIDTH-1:0]         window;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0]   lane_instr;
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]    lane_pc;
    instr_class_e [FETCH_WIDTH-1:0]            lane_class;

    function automatic instr_class_e classify(input logic [INSTR_WIDTH-1:0] instr);
        logic [OPC_WIDTH-1:0] opc;
        opc = instr[OPC_MSB:OPC_LSB];
        if (opc == OPC_JUMP_B || opc == OPC_JUMP_BL) begin
            return CLS_JUMP;
        end else if (opc >= OPC_BRANCH_LO && opc <= OPC_BRANCH_HI) begin
            return CLS_BRANCH;
        end else if (opc == OPC_MEM) begin
            return CLS_MEM;
        end
        return CLS_ALU;
    endfunction

    // Ports still owed a response after this cycle
    assign req_left = icache_req_o & ~icache_valid_i;

    // Responses of a flushed block must drain before the ports are reused
    assign ports_free = !drop_q || (req_left == '0);

    assign accept = ftq_valid_i && !flush_i && ports_free &&
                    (state_q == IFU_IDLE || (state_q == IFU_HOLD && !stall_i));
    assign ftq_accept_o = accept;

    assign lines_done = (state_q == IFU_WAIT) && (req_left == '0);
    assign line_base = ftq_pc_i & ~ADDR_WIDTH'(LINE_BYTES - 1);

    // Take data arriving this cycle directly
    always_comb begin
        for (int p = 0; p < CACHE_PORTS; p++) begin
            line_m[p] = (icache_req_o[p] && icache_valid_i[p]) ? icache_data_i[p] : line_q[p];
        end
    end

    // Align four words from the start word onward, then predecode
    always_comb begin
        window = {line_m[1], line_m[0]};
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_instr[i] = window[(int'(blk_pc_q[3:2]) + i) * INSTR_WIDTH +: INSTR_WIDTH];
            lane_pc[i] = blk_pc_q + ADDR_WIDTH'(i * INSTR_BYTES);
            lane_class[i] = classify(lane_instr[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IFU_IDLE;
            icache_req_o <= '0;
            drop_q <= 1'b0;
            instr_valid_o <= '0;
        end else begin
            // Requests stay up until answered, flush or not
            icache_req_o <= req_left;
            if (flush_i) begin
                state_q <= IFU_IDLE;
                drop_q <= |req_left;
                instr_valid_o <= '0;
            end else begin
                if (req_left == '0) begin
                    drop_q <= 1'b0;
                end
                case (state_q)
                    IFU_IDLE: begin
                        if (accept) begin
                            state_q <= IFU_WAIT;
                        end
                    end
                    IFU_WAIT: begin
                        if (lines_done) begin
                            state_q <= IFU_HOLD;
                            instr_valid_o <= '1;
                        end
                    end
                    IFU_HOLD: begin
                        if (!stall_i) begin
                            instr_valid_o <= '0;
                            state_q <= accept ? IFU_WAIT : IFU_IDLE;
                        end
                    end
                    default: begin
                        state_q <= IFU_IDLE;
                    end
                endcase
                if (accept) begin
                    icache_req_o <= {ftq_cross_i, 1'b1};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            blk_pc_q <= ftq_pc_i;
            icache_addr_o[0] <= line_base;
            icache_addr_o[1] <= line_base + ADDR_WIDTH'(LINE_BYTES);
        end
        if (state_q == IFU_WAIT) begin
            line_q <= line_m;
        end
        if (lines_done) begin
            instr_pc_o <= lane_pc;
            instr_o <= lane_instr;
            instr_class_o <= lane_class;
        end
    end

endmodule

//--- src/frontend.sv
`timescale 1ns/1ps

module frontend
    import fetch_cfg_pkg::*;
    import instr_info_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,

    // Instruction cache
    output logic [CACHE_PORTS-1:0]                   icache_req_o,
    output logic [CACHE_PORTS-1:0][ADDR_WIDTH-1:0]   icache_addr_o,
    input  logic [CACHE_PORTS-1:0]                   icache_valid_i,
    input  logic [CACHE_PORTS-1:0][LINE_WIDTH-1:0]   icache_data_i,

    // Backend
    input  logic [ADDR_WIDTH-1:0]                    backend_next_pc_i,
    input  logic                                     backend_flush_i,
    input  logic                                     backend_commit_i,

    // Instruction buffer
    input  logic                                     instr_stall_i,
    output logic [FETCH_WIDTH-1:0]                   instr_valid_o,
    output logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]   instr_pc_o,
    output logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0]  instr_o,
    output instr_class_e [FETCH_WIDTH-1:0]           instr_class_o
);

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] next_pc;
    logic                  ftq_full;
    logic                  blk_valid;
    logic                  blk_cross;
    logic                  ifu_blk_valid;
    logic [ADDR_WIDTH-1:0] ifu_blk_pc;
    logic                  ifu_blk_cross;
    logic                  ifu_accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // Redirect first, then hold, then step one block
    always_comb begin
        if (backend_flush_i) begin
            next_pc = backend_next_pc_i;
        end else if (instr_stall_i || ftq_full) begin
            next_pc = pc_q;
        end else begin
            next_pc = pc_q + ADDR_WIDTH'(BLOCK_BYTES);
        end
    end

    // Sequential block of four, spills into the next line when unaligned
    assign blk_valid = !ftq_full && !instr_stall_i && !backend_flush_i;
    assign blk_cross = (pc_q[3:2] != 2'b00);

    ftq u_ftq (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (backend_flush_i),
        .blk_valid_i  (blk_valid),
        .blk_pc_i     (pc_q),
        .blk_cross_i  (blk_cross),
        .full_o       (ftq_full),
        .commit_i     (backend_commit_i),
        .ifu_valid_o  (ifu_blk_valid),
        .ifu_pc_o     (ifu_blk_pc),
        .ifu_cross_o  (ifu_blk_cross),
        .ifu_accept_i (ifu_accept)
    );

    ifu u_ifu (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (backend_flush_i),
        .ftq_valid_i    (ifu_blk_valid),
        .ftq_pc_i       (ifu_blk_pc),
        .ftq_cross_i    (ifu_blk_cross),
        .ftq_accept_o   (ifu_accept),
        .icache_req_o   (icache_req_o),
        .icache_addr_o  (icache_addr_o),
        .icache_valid_i (icache_valid_i),
        .icache_data_i  (icache_data_i),
        .stall_i        (instr_stall_i),
        .instr_valid_o  (instr_valid_o),
        .instr_pc_o     (instr_pc_o),
        .instr_o        (instr_o),
        .instr_class_o  (instr_class_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Held low for ten rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- tb/frontend_assertions.sv
`timescale 1ns/1ps

module frontend_assertions
    import fetch_cfg_pkg::*;
    import instr_info_pkg::*;
(
    input logic                                    clk,
    input logic                                    rst_n,
    input logic                                    flush_i,
    input logic                                    stall_i,
    input logic [CACHE_PORTS-1:0]                  icache_req_o,
    input logic [CACHE_PORTS-1:0]                  icache_valid_i,
    input logic [FETCH_WIDTH-1:0]                  instr_valid_o,
    input logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  instr_pc_o,
    input logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_o,
    input instr_class_e [FETCH_WIDTH-1:0]          instr_class_o
);

    int                     fail_count = 0;
    logic [CACHE_PORTS-1:0] req_open;

    // Ports still waiting on a response
    assign req_open = icache_req_o & ~icache_valid_i;

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_open != '0 |=> (icache_req_o & $past(req_open)) == $past(req_open))
    else begin
        $error("cache request dropped before its response arrived");
        fail_count++;
    end

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid_o != '0 && stall_i && !flush_i
        |=> $stable(instr_valid_o) && $stable(instr_pc_o) && $stable(instr_o)
            && $stable(instr_class_o))
    else begin
        $error("lanes changed while stalled");
        fail_count++;
    end

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> instr_valid_o == '0)
    else begin
        $error("valid lanes in the cycle after a flush");
        fail_count++;
    end

endmodule

//--- tb/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
    import fetch_cfg_pkg::*;
    import instr_info_pkg::*;
();

    logic                                    clk;
    logic                                    rst_n;
    logic [CACHE_PORTS-1:0]                  icache_req;
    logic [CACHE_PORTS-1:0][ADDR_WIDTH-1:0]  icache_addr;
    logic [CACHE_PORTS-1:0]                  icache_valid;
    logic [CACHE_PORTS-1:0][LINE_WIDTH-1:0]  icache_data;
    logic [ADDR_WIDTH-1:0]                   next_pc;
    logic                                    flush;
    logic                                    commit;
    logic                                    stall;
    logic [FETCH_WIDTH-1:0]                  instr_valid;
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  instr_pc;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr;
    instr_class_e [FETCH_WIDTH-1:0]          instr_class;

    // Memory image rule, indexed by word index mod 6
    logic [5:0]   opc_table [6] = '{6'b010100, 6'b010110, 6'b001010,
                                    6'b000000, 6'b010101, 6'b011011};
    instr_class_e cls_table [6] = '{CLS_JUMP, CLS_BRANCH, CLS_MEM,
                                    CLS_ALU, CLS_JUMP, CLS_BRANCH};

    logic [31:0]            lfsr = 32'h72cf_d22e;
    logic [CACHE_PORTS-1:0] busy = '0;
    int                     wait_cnt [CACHE_PORTS];
    logic [ADDR_WIDTH-1:0]  req_addr [CACHE_PORTS];
    logic                   p1_seen = 1'b0;
    logic                   auto_commit = 1'b0;
    logic [ADDR_WIDTH-1:0]  exp_pc = RESET_PC;
    int                     errors = 0;
    int                     groups = 0;
    int                     pending = 0;
    int                     cycles = 0;
    int                     limit = 40;
    string                  cmds [$];
    string                  args [$];

    tb_clock_gen u_clock (.clk_o(clk), .rst_n_o(rst_n));

    frontend DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .icache_req_o      (icache_req),
        .icache_addr_o     (icache_addr),
        .icache_valid_i    (icache_valid),
        .icache_data_i     (icache_data),
        .backend_next_pc_i (next_pc),
        .backend_flush_i   (flush),
        .backend_commit_i  (commit),
        .instr_stall_i     (stall),
        .instr_valid_o     (instr_valid),
        .instr_pc_o        (instr_pc),
        .instr_o           (instr),
        .instr_class_o     (instr_class)
    );

    bind ifu frontend_assertions u_checks (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic int word_slot(input logic [ADDR_WIDTH-1:0] addr);
        return int'(addr[31:2] % 30'd6);
    endfunction

    function automatic logic [31:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
        return {opc_table[word_slot(addr)], addr[27:2]};
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_at(input logic [ADDR_WIDTH-1:0] addr);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = word_at((addr & ~32'hf) + ADDR_WIDTH'(w * 4));
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Each port answers 0 to 3 cycles after its request is first seen
    task automatic cache_step();
        for (int p = 0; p < CACHE_PORTS; p++) begin
            icache_valid[p] = 1'b0;
            if (icache_req[p] && !busy[p]) begin
                busy[p] = 1'b1;
                req_addr[p] = icache_addr[p];
                p1_seen = (p == 1);
                wait_cnt[p] = 0;
                for (int b = 0; b < 2; b++) begin
                    wait_cnt[p] = wait_cnt[p] | (int'(lfsr[0]) << b);
                    lfsr = lfsr_step(lfsr);
                end
            end
            if (busy[p] && wait_cnt[p] == 0) begin
                icache_valid[p] = 1'b1;
                icache_data[p] = line_at(req_addr[p]);
                busy[p] = 1'b0;
            end else if (busy[p]) begin
                wait_cnt[p]--;
            end
        end
    endtask

    task automatic check_group();
        logic [ADDR_WIDTH-1:0] pc;
        assert (p1_seen == (exp_pc[3:2] != 2'b00)) else begin
            $display("port 1 use wrong for block at %h at %0t", exp_pc, $time);
            errors++;
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pc = exp_pc + ADDR_WIDTH'(i * 4);
            check_value($sformatf("instr_pc_o[%0d]", i), instr_pc[i], pc);
            check_value($sformatf("instr_o[%0d]", i), instr[i], word_at(pc));
            check_value($sformatf("instr_class_o[%0d]", i), 32'(instr_class[i]),
                        32'(cls_table[word_slot(pc)]));
        end
        exp_pc += 16;
        groups++;
    endtask

    // One cycle, inputs change 1 ns after the edge
    task automatic tick(input logic stall_now, input logic flush_now,
                        input logic [31:0] target, output logic got);
        @(posedge clk);
        #1;
        cache_step();
        got = 1'b0;
        assert (instr_valid == '0 || &instr_valid) else begin
            $display("only some lanes valid at %0t", $time);
            errors++;
        end
        if (&instr_valid && !stall_now && !flush_now) begin
            check_group();
            pending++;
            got = 1'b1;
        end
        stall = stall_now;
        flush = flush_now;
        next_pc = target;
        commit = 1'b0;
        if (flush_now) begin
            exp_pc = target;
            pending = 0;
        end else if (auto_commit && pending > 0) begin
            commit = 1'b1;
            pending--;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, expected groups never came", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int    fd;
        int    r;
        int    got_n;
        int    errs_before;
        logic  got;
        string line;
        string cmd;
        string arg;
        icache_valid = '0;
        icache_data = '0;
        next_pc = '0;
        flush = 1'b0;
        commit = 1'b0;
        stall = 1'b0;
        fd = $fopen("tb/frontend_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file tb/frontend_vectors.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    r = $sscanf(line, "%s %s", cmd, arg);
                    cmds.push_back(cmd);
                    args.push_back(arg);
                    limit += 8;
                    if (cmd == "R") begin
                        limit += 64 * arg.atoi();
                    end else if (cmd == "S" || cmd == "Q") begin
                        limit += arg.atoi();
                    end
                end
            end
            $fclose(fd);
        end
        wait (rst_n === 1'b1);
        foreach (cmds[k]) begin
            errs_before = errors;
            got_n = 0;
            if (cmds[k] == "R") begin
                while (got_n < args[k].atoi()) begin
                    tick(1'b0, 1'b0, 32'h0, got);
                    if (got) got_n++;
                end
            end else if (cmds[k] == "F") begin
                tick(1'b0, 1'b1, args[k].atohex(), got);
            end else if (cmds[k] == "S") begin
                repeat (args[k].atoi()) tick(1'b1, 1'b0, 32'h0, got);
            end else if (cmds[k] == "Q") begin
                repeat (args[k].atoi()) begin
                    tick(1'b0, 1'b0, 32'h0, got);
                    if (got) got_n++;
                end
                assert (got_n == 0) else begin
                    $display("%0d groups came out while fetch should be stopped", got_n);
                    errors++;
                end
            end else if (cmds[k] == "C") begin
                auto_commit = (args[k] == "on");
            end else begin
                $display("unknown vector command %s", cmds[k]);
                errors++;
            end
            $display("test %0d %s %s: %0d groups, %0d errors", k + 1, cmds[k], args[k],
                     got_n, errors - errs_before);
        end
        $display("%0d tests, %0d groups, %0d check errors, %0d assertion failures",
                 cmds.size(), groups, errors, DUT.u_ifu.u_checks.fail_count);
        if (errors == 0 && DUT.u_ifu.u_checks.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/frontend_vectors.txt
# Columns: command argument
# R n run n groups, F addr flush to hex addr, S n stall n cycles,
# C on/off commit each group, Q n no group expected for n cycles
C on
R 8
S 5
R 4
F 1c000108
R 6
S 7
R 5
F 1c000204
C off
R 4
Q 20
C on
R 6
F 1c00030c
R 3
S 3
F 1c000400
R 5
F 1c00050c
F 1c000608
R 6

//--- frontend.f
src/fetch_cfg_pkg.sv
src/instr_info_pkg.sv
src/ftq.sv
src/ifu.sv
src/frontend.sv
tb/tb_clock_gen.sv
tb/frontend_assertions.sv
tb/frontend_tb.sv

//--- Makefile
TOOL      := verilator
TOP       := frontend_tb
FILELIST  := frontend.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
RUNFLAGS  := +verilator+error+limit+1000
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
